//--- rtl/exu_pkg.sv
// shared widths, types and payload structs for the execution stage
// only the RV32I subset ADD, SUB, AND, OR, XOR, ADDI and LW is decoded
// widths are fixed for RV32; XLEN other than 32 is not supported
package exu_pkg;

  parameter int XLEN    = 32;
  parameter int RFIDX_W = 5;
  parameter int INSTR_W = 32;

  typedef logic [XLEN-1:0]    xlen_t;
  typedef logic [RFIDX_W-1:0] rfidx_t;
  typedef logic [INSTR_W-1:0] instr_t;

  // single-cycle ALU operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // decoded instruction, enables already cleared for x0
  typedef struct packed {
    alu_op_e op;
    logic    is_load;
    logic    use_imm;
    logic    rs1en;
    logic    rs2en;
    logic    rdwen;
    rfidx_t  rs1idx;
    rfidx_t  rs2idx;
    rfidx_t  rdidx;
    xlen_t   imm;
  } dec_info_t;

  typedef struct packed {
    alu_op_e op;
    xlen_t   opa;
    xlen_t   opb;
    rfidx_t  rdidx;
    logic    rdwen;
  } alu_req_t;

  // one register-file write
  typedef struct packed {
    logic   ena;
    rfidx_t rdidx;
    xlen_t  wdat;
  } wbck_t;

endpackage

//--- rtl/exu_decode.sv
// instruction decoder for the kept RV32I subset
// unknown encodings come out with rdwen and is_load low and retire as no-ops
// source and destination enables are dropped when the index is x0
`timescale 1ns/100ps

module exu_decode (
  input  exu_pkg::instr_t    i_instr,
  output exu_pkg::dec_info_t o_dec
);

  import exu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_op;
  logic       is_addi;
  logic       is_lw;
  logic       f7_zero;
  logic       f7_alt;
  logic       r_known;
  logic       any_known;
  alu_op_e    op_sel;

  assign opcode  = i_instr[6:0];
  assign funct3  = i_instr[14:12];
  assign funct7  = i_instr[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  assign is_op   = (opcode == 7'b0110011);
  assign is_addi = (opcode == 7'b0010011) & (funct3 == 3'b000);
  assign is_lw   = (opcode == 7'b0000011) & (funct3 == 3'b010);

  // register-register ops, funct7 picks ADD or SUB
  always_comb begin
    r_known = 1'b0;
    op_sel  = ALU_ADD;
    if (is_op) begin
      case (funct3)
        3'b000: begin
          r_known = f7_zero | f7_alt;
          op_sel  = f7_alt ? ALU_SUB : ALU_ADD;
        end
        3'b100: begin
          r_known = f7_zero;
          op_sel  = ALU_XOR;
        end
        3'b110: begin
          r_known = f7_zero;
          op_sel  = ALU_OR;
        end
        3'b111: begin
          r_known = f7_zero;
          op_sel  = ALU_AND;
        end
        default: begin
          r_known = 1'b0;
        end
      endcase
    end
  end

  assign any_known = r_known | is_addi | is_lw;

  // fields
  assign o_dec.op      = op_sel;
  assign o_dec.is_load = is_lw;
  assign o_dec.use_imm = is_addi | is_lw;
  assign o_dec.rs1idx  = i_instr[19:15];
  assign o_dec.rs2idx  = i_instr[24:20];
  assign o_dec.rdidx   = i_instr[11:7];
  assign o_dec.imm     = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};

  // x0 never hazards and is never written
  assign o_dec.rs1en = any_known & (i_instr[19:15] != '0);
  assign o_dec.rs2en = r_known & (i_instr[24:20] != '0);
  assign o_dec.rdwen = any_known & (i_instr[11:7] != '0);

endmodule

//--- rtl/exu_dispatch.sv
// dispatch for the execution stage, purely combinational
// ALU instructions retire in the accept cycle; loads leave on the AGU port
// any OITF match stalls the input, so loaded values are never bypassed
`timescale 1ns/100ps

module exu_dispatch (
  input  logic                i_instr_valid,
  output logic                o_instr_ready,
  input  exu_pkg::dec_info_t  i_dec,
  input  exu_pkg::xlen_t      i_rs1,
  input  exu_pkg::xlen_t      i_rs2,
  input  logic                i_hazard,
  input  logic                i_oitf_full,
  input  logic                i_alu_grant,
  output exu_pkg::alu_req_t   o_alu_req,
  output logic                o_alu_valid,
  output logic                o_agu_valid,
  input  logic                i_agu_ready,
  output exu_pkg::xlen_t      o_agu_addr,
  output logic                o_oitf_dis
);

  import exu_pkg::*;

  xlen_t opb;
  logic  ld_go;
  logic  alu_go;

  // second operand from rs2 or the I-immediate
  assign opb = i_dec.use_imm ? i_dec.imm : i_rs2;

  // load address, rs1 plus offset
  assign o_agu_addr = i_rs1 + i_dec.imm;

  //////////////////////////////////////////////////////////////////////////
  // routing and handshake

  // load needs a free OITF slot, ALU needs the write-back port
  assign ld_go  = i_dec.is_load & ~i_hazard & ~i_oitf_full;
  assign alu_go = ~i_dec.is_load & ~i_hazard & i_alu_grant;

  assign o_agu_valid = i_instr_valid & ld_go;
  assign o_alu_valid = i_instr_valid & alu_go;

  // push to OITF only when the load command is taken
  assign o_oitf_dis = o_agu_valid & i_agu_ready;

  assign o_instr_ready = i_dec.is_load ? (ld_go & i_agu_ready) : alu_go;

  // ALU request
  assign o_alu_req.op    = i_dec.op;
  assign o_alu_req.opa   = i_rs1;
  assign o_alu_req.opb   = opb;
  assign o_alu_req.rdidx = i_dec.rdidx;
  assign o_alu_req.rdwen = i_dec.rdwen;

endmodule

//--- rtl/exu_regfile.sv
// 32 x 32-bit integer register file, one write port, two async read ports
// x0 has no storage and always reads zero
// a write and a read of the same index in one cycle returns the old value
`timescale 1ns/100ps

module exu_regfile (
  input  logic            clk,
  input  logic            i_arst_n,
  input  exu_pkg::rfidx_t i_rs1idx,
  input  exu_pkg::rfidx_t i_rs2idx,
  output exu_pkg::xlen_t  o_rs1,
  output exu_pkg::xlen_t  o_rs2,
  input  exu_pkg::wbck_t  i_wbck
);

  import exu_pkg::*;

  xlen_t rf_q [1:31];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wbck.ena && (i_wbck.rdidx != '0)) begin
      rf_q[i_wbck.rdidx] <= i_wbck.wdat;
    end
  end

  // read ports
  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

endmodule

//--- rtl/exu_oitf.sv
// outstanding-instruction FIFO for loads in flight
// holds only the destination index; loads must return in push order
// OITF_DEPTH must be a power of two from 2 to 8
// the caller must not push when full nor pop when empty
`timescale 1ns/100ps

module exu_oitf #(
  parameter int OITF_DEPTH = 2
) (
  input  logic               clk,
  input  logic               i_arst_n,
  input  logic               i_dis_ena,
  input  exu_pkg::rfidx_t    i_dis_rdidx,
  input  logic               i_ret_ena,
  input  exu_pkg::dec_info_t i_chk,
  output exu_pkg::rfidx_t    o_ret_rdidx,
  output logic               o_hazard,
  output logic               o_full,
  output logic               o_empty
);

  import exu_pkg::*;

  localparam int PTR_W = $clog2(OITF_DEPTH);

  rfidx_t                rdidx_q [OITF_DEPTH];
  logic [OITF_DEPTH-1:0] vld_q;
  // top bit of each pointer is the wrap flag
  logic [PTR_W:0]        wr_ptr_q;
  logic [PTR_W:0]        rd_ptr_q;
  logic [PTR_W-1:0]      wr_idx;
  logic [PTR_W-1:0]      rd_idx;
  logic [OITF_DEPTH-1:0] match;

  assign wr_idx = wr_ptr_q[PTR_W-1:0];
  assign rd_idx = rd_ptr_q[PTR_W-1:0];

  //////////////////////////////////////////////////////////////////////////
  // pointers and entry valids

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      vld_q    <= '0;
    end else begin
      if (i_dis_ena) begin
        wr_ptr_q      <= wr_ptr_q + 1'b1;
        vld_q[wr_idx] <= 1'b1;
      end
      if (i_ret_ena) begin
        rd_ptr_q      <= rd_ptr_q + 1'b1;
        vld_q[rd_idx] <= 1'b0;
      end
    end
  end

  // destination index storage
  always_ff @(posedge clk) begin
    if (i_dis_ena) begin
      rdidx_q[wr_idx] <= i_dis_rdidx;
    end
  end

  assign o_empty = (wr_ptr_q == rd_ptr_q);
  assign o_full  = (wr_idx == rd_idx) & (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]);

  // head entry is the next load to return
  assign o_ret_rdidx = rdidx_q[rd_idx];

  //////////////////////////////////////////////////////////////////////////
  // RAW and WAW check against every live entry

  always_comb begin
    for (int i = 0; i < OITF_DEPTH; i++) begin
      match[i] = vld_q[i] & (
                   (i_chk.rs1en & (i_chk.rs1idx == rdidx_q[i])) |
                   (i_chk.rs2en & (i_chk.rs2idx == rdidx_q[i])) |
                   (i_chk.rdwen & (i_chk.rdidx  == rdidx_q[i])));
    end
  end

  assign o_hazard = |match;

endmodule

//--- rtl/exu_alu.sv
// single-cycle integer ALU
// result is presented as a write-back in the same cycle as the request
// unknown op codes give zero, but the decoder never produces them
`timescale 1ns/100ps

module exu_alu (
  input  logic              i_valid,
  input  exu_pkg::alu_req_t i_req,
  output exu_pkg::wbck_t    o_wbck
);

  import exu_pkg::*;

  xlen_t res;

  always_comb begin
    case (i_req.op)
      ALU_ADD: begin
        res = i_req.opa + i_req.opb;
      end
      ALU_SUB: begin
        res = i_req.opa - i_req.opb;
      end
      ALU_AND: begin
        res = i_req.opa & i_req.opb;
      end
      ALU_OR: begin
        res = i_req.opa | i_req.opb;
      end
      ALU_XOR: begin
        res = i_req.opa ^ i_req.opb;
      end
      default: begin
        res = '0;
      end
    endcase
  end

  // no-ops arrive with rdwen low
  assign o_wbck.ena   = i_valid & i_req.rdwen;
  assign o_wbck.rdidx = i_req.rdidx;
  assign o_wbck.wdat  = res;

endmodule

//--- rtl/exu_wbck.sv
// final write-back arbiter, load return over ALU result
// the load unit is never back-pressured; a return also retires the OITF head
// a load to x0 retires without a register write
`timescale 1ns/100ps

module exu_wbck (
  input  exu_pkg::wbck_t  i_alu_wbck,
  input  logic            i_lsu_valid,
  output logic            o_lsu_ready,
  input  exu_pkg::xlen_t  i_lsu_rdata,
  input  exu_pkg::rfidx_t i_ret_rdidx,
  output logic            o_alu_grant,
  output logic            o_ret_ena,
  output exu_pkg::wbck_t  o_wbck
);

  assign o_lsu_ready = 1'b1;
  assign o_ret_ena   = i_lsu_valid & o_lsu_ready;

  // ALU only gets the port when no load is returning
  assign o_alu_grant = ~i_lsu_valid;

  always_comb begin
    if (o_ret_ena) begin
      o_wbck.ena   = (i_ret_rdidx != '0);
      o_wbck.rdidx = i_ret_rdidx;
      o_wbck.wdat  = i_lsu_rdata;
    end else begin
      o_wbck = i_alu_wbck;
    end
  end

endmodule

//--- rtl/exu_top.sv
// in-order execution stage for a small RV32I subset
// ALU results are written in the accept cycle, loads through the OITF
// load responses must come back in command order, no tag is carried
// OITF_DEPTH sets the loads in flight, power of two from 2 to 8
`timescale 1ns/100ps

module exu_top #(
  parameter int OITF_DEPTH = 2
) (
  input  logic            clk,
  input  logic            i_arst_n,
  // instruction in
  input  logic            i_instr_valid,
  output logic            o_instr_ready,
  input  exu_pkg::instr_t i_instr,
  // load command out
  output logic            o_agu_valid,
  input  logic            i_agu_ready,
  output exu_pkg::xlen_t  o_agu_addr,
  // load return in
  input  logic            i_lsu_valid,
  output logic            o_lsu_ready,
  input  exu_pkg::xlen_t  i_lsu_rdata,
  // write-back and status
  output exu_pkg::wbck_t  o_wbck,
  output logic            o_oitf_empty
);

  import exu_pkg::*;

  dec_info_t dec;
  xlen_t     rf_rs1;
  xlen_t     rf_rs2;
  alu_req_t  alu_req;
  logic      alu_valid;
  wbck_t     alu_wbck;
  logic      alu_grant;
  logic      oitf_hazard;
  logic      oitf_full;
  logic      oitf_dis;
  logic      oitf_ret;
  rfidx_t    ret_rdidx;

  //////////////////////////////////////////////////////////////////////////
  // input side

  exu_decode u_exu_decode (
    .i_instr (i_instr),
    .o_dec   (dec)
  );

  exu_dispatch u_exu_dispatch (
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .i_dec         (dec),
    .i_rs1         (rf_rs1),
    .i_rs2         (rf_rs2),
    .i_hazard      (oitf_hazard),
    .i_oitf_full   (oitf_full),
    .i_alu_grant   (alu_grant),
    .o_alu_req     (alu_req),
    .o_alu_valid   (alu_valid),
    .o_agu_valid   (o_agu_valid),
    .i_agu_ready   (i_agu_ready),
    .o_agu_addr    (o_agu_addr),
    .o_oitf_dis    (oitf_dis)
  );

  //////////////////////////////////////////////////////////////////////////
  // register file, ALU and OITF

  exu_regfile u_exu_regfile (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_rs1idx (dec.rs1idx),
    .i_rs2idx (dec.rs2idx),
    .o_rs1    (rf_rs1),
    .o_rs2    (rf_rs2),
    .i_wbck   (o_wbck)
  );

  exu_alu u_exu_alu (
    .i_valid (alu_valid),
    .i_req   (alu_req),
    .o_wbck  (alu_wbck)
  );

  exu_oitf #(
    .OITF_DEPTH (OITF_DEPTH)
  ) u_exu_oitf (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_dis_ena   (oitf_dis),
    .i_dis_rdidx (dec.rdidx),
    .i_ret_ena   (oitf_ret),
    .i_chk       (dec),
    .o_ret_rdidx (ret_rdidx),
    .o_hazard    (oitf_hazard),
    .o_full      (oitf_full),
    .o_empty     (o_oitf_empty)
  );

  // output side
  exu_wbck u_exu_wbck (
    .i_alu_wbck  (alu_wbck),
    .i_lsu_valid (i_lsu_valid),
    .o_lsu_ready (o_lsu_ready),
    .i_lsu_rdata (i_lsu_rdata),
    .i_ret_rdidx (ret_rdidx),
    .o_alu_grant (alu_grant),
    .o_ret_ena   (oitf_ret),
    .o_wbck      (o_wbck)
  );

endmodule

//--- sim/exu_tb.sv
// testbench for exu_top that replays sim/exu_trace.txt from the project root
// each trace line gives an instruction, its expected rd (0 = no write) and value
// the load-unit model answers in order with the inverse of the address
// inputs change 10 ns after the rising edge and outputs are sampled at 90 ns
`timescale 1ns/100ps

module exu_tb;

  import exu_pkg::*;

  localparam int MAX_INSTR  = 64;
  localparam int OITF_DEPTH = 2;

  logic      clk = 1'b0;
  logic      i_arst_n;
  logic      i_instr_valid;
  logic      o_instr_ready;
  instr_t    i_instr;
  logic      o_agu_valid;
  logic      i_agu_ready;
  xlen_t     o_agu_addr;
  logic      i_lsu_valid;
  logic      o_lsu_ready;
  xlen_t     i_lsu_rdata;
  wbck_t     o_wbck;
  logic      o_oitf_empty;

  logic [31:0] trace_mem [0:3*MAX_INSTR-1];
  int          trace_len;
  int          pc;
  // register writes seen on o_wbck
  int          writes_seen;
  int          writes_expected;
  logic        trace_ready = 1'b0;
  integer      seed = 32'h563e;

  // load unit state and the writes it still owes
  xlen_t       ld_addr [$];
  int          ld_wait [$];
  rfidx_t      exp_idx [$];
  xlen_t       exp_val [$];

  always #50 clk = ~clk;

  exu_top #(
    .OITF_DEPTH (OITF_DEPTH)
  ) u_exu_top (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .i_instr       (i_instr),
    .o_agu_valid   (o_agu_valid),
    .i_agu_ready   (i_agu_ready),
    .o_agu_addr    (o_agu_addr),
    .i_lsu_valid   (i_lsu_valid),
    .o_lsu_ready   (o_lsu_ready),
    .i_lsu_rdata   (i_lsu_rdata),
    .o_wbck        (o_wbck),
    .o_oitf_empty  (o_oitf_empty)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // LW is opcode 0000011 with funct3 010
  function automatic logic is_lw(input logic [31:0] word);
    return (word[6:0] == 7'b0000011) && (word[14:12] == 3'b010);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // one clock cycle of stimulus and checking

  task automatic run_cycle();
    logic   ld;
    logic   acc;
    logic   lsu_ret;
    logic   agu_fire;
    rfidx_t idx;
    xlen_t  val;
    int     delay;
    @(posedge clk);
    #10;
    i_instr_valid = (pc < trace_len);
    i_instr       = (pc < trace_len) ? trace_mem[3*pc] : '0;
    i_agu_ready   = (($random(seed) & 3) != 0);
    delay         = $unsigned($random(seed)) % 4;
    // oldest command answers once its wait has run out
    i_lsu_valid = 1'b0;
    i_lsu_rdata = '0;
    if (ld_addr.size() > 0) begin
      if (ld_wait[0] == 0) begin
        i_lsu_valid = 1'b1;
        i_lsu_rdata = ~ld_addr[0];
      end else begin
        ld_wait[0] = ld_wait[0] - 1;
      end
    end
    #80;
    lsu_ret  = i_lsu_valid & o_lsu_ready;
    acc      = i_instr_valid & o_instr_ready;
    agu_fire = o_agu_valid & i_agu_ready;
    ld       = i_instr_valid & is_lw(i_instr);
    idx      = (pc < trace_len) ? trace_mem[3*pc+1][4:0] : '0;
    val      = (pc < trace_len) ? trace_mem[3*pc+2] : '0;
    check_value("o_lsu_ready", o_lsu_ready, 1'b1);
    check_value("o_agu_valid & i_agu_ready", agu_fire, acc & ld);
    // a full OITF holds back the next load even while one returns
    if (acc && ld) begin
      check_value("loads in flight", ld_addr.size() < OITF_DEPTH, 1'b1);
    end
    if (o_wbck.ena) begin
      writes_seen++;
    end
    if (lsu_ret && i_instr_valid && !ld) begin
      check_value("o_instr_ready", o_instr_ready, 1'b0);
    end
    if (lsu_ret) begin
      check_value("o_wbck.ena", o_wbck.ena, exp_idx[0] != 0);
      if (exp_idx[0] != 0) begin
        check_value("o_wbck.rdidx", o_wbck.rdidx, exp_idx[0]);
        check_value("o_wbck.wdat", o_wbck.wdat, exp_val[0]);
      end
      void'(ld_addr.pop_front());
      void'(ld_wait.pop_front());
      void'(exp_idx.pop_front());
      void'(exp_val.pop_front());
    end
    if (acc && ld) begin
      check_value("o_agu_addr", o_agu_addr, ~val);
      ld_addr.push_back(o_agu_addr);
      ld_wait.push_back(delay);
      exp_idx.push_back(idx);
      exp_val.push_back(val);
    end else if (acc) begin
      check_value("o_wbck.ena", o_wbck.ena, idx != 0);
      if (idx != 0) begin
        check_value("o_wbck.rdidx", o_wbck.rdidx, idx);
        check_value("o_wbck.wdat", o_wbck.wdat, val);
      end
    end else if (!lsu_ret) begin
      check_value("o_wbck.ena", o_wbck.ena, 1'b0);
    end
    if (acc) begin
      pc++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    i_arst_n      = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    i_agu_ready   = 1'b0;
    i_lsu_valid   = 1'b0;
    i_lsu_rdata   = '0;
    pc              = 0;
    trace_len       = 0;
    writes_seen     = 0;
    writes_expected = 0;
    $readmemh("sim/exu_trace.txt", trace_mem);
    while (trace_len < MAX_INSTR && !$isunknown(trace_mem[3*trace_len])) begin
      if (trace_mem[3*trace_len+1][4:0] != 0) begin
        writes_expected++;
      end
      trace_len++;
    end
    if (trace_len == 0) begin
      $display("the trace file sim/exu_trace.txt is missing or holds no instructions");
      $display("Done: errors found");
      $fatal(1, "no stimulus");
    end else begin
      trace_ready = 1'b1;
      repeat (4) @(posedge clk);
      check_value("o_agu_valid", o_agu_valid, 1'b0);
      check_value("o_wbck.ena", o_wbck.ena, 1'b0);
      check_value("o_oitf_empty", o_oitf_empty, 1'b1);
      #10;
      i_arst_n = 1'b1;
      while (pc < trace_len || ld_addr.size() > 0) begin
        run_cycle();
      end
      // let the last pop settle in the OITF
      run_cycle();
      check_value("o_oitf_empty", o_oitf_empty, 1'b1);
      check_value("register writes", writes_seen, writes_expected);
      $display("Done: no errors");
      $finish;
    end
  end

  // watchdog allows 20 cycles per trace instruction
  initial begin
    wait (trace_ready);
    repeat (trace_len * 20) @(posedge clk);
    $display("timeout: the trace did not finish within %0d cycles", trace_len * 20);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sim/exu_trace.txt
// each line holds an instruction word, the expected rd and the expected value
// rd 00 means no register write; a load returns the inverse of its address
// setup with ADDI
10000093 01 00000100
0F000113 02 000000F0
FFF00193 03 FFFFFFFF
00208233 04 000001F0
// loads mixed with ALU work, RAW on x5 and x7
0080A283 05 FFFFFEF7
40218333 06 FFFFFF0F
FFC22383 07 FFFFFE13
0062C433 08 000001F8
0033F4B3 09 FFFFFE13
// write to x0, unknown encoding, then a read of x0
00508013 00 00000000
00000000 00 00000000
00806533 0A 000001F8
// loads fill the OITF, independent ALU behind them
00052583 0B FFFFFE07
01012603 0C FFFFFEFF
0040A683 0D FFFFFEFB
00148713 0E FFFFFE14
0000A003 00 FFFFFEFF
00C587B3 0F FFFFFD06
40E682B3 05 000000E7
// WAW on x16
02002803 10 FFFFFFDF
00700813 10 00000007

//--- exu_top.f
rtl/exu_pkg.sv
rtl/exu_decode.sv
rtl/exu_dispatch.sv
rtl/exu_regfile.sv
rtl/exu_oitf.sv
rtl/exu_alu.sv
rtl/exu_wbck.sv
rtl/exu_top.sv
sim/exu_tb.sv

//--- Bender.yml
package:
  name: exu

sources:
  - rtl/exu_pkg.sv
  - rtl/exu_decode.sv
  - rtl/exu_dispatch.sv
  - rtl/exu_regfile.sv
  - rtl/exu_oitf.sv
  - rtl/exu_alu.sv
  - rtl/exu_wbck.sv
  - rtl/exu_top.sv
  - target: simulation
    files:
      - sim/exu_tb.sv
